/* compile.f */
+incdir+.
erx_pkg.sv
erx_word_decode.sv
erx_packet_remap.sv
erx_slow_handoff.sv
erx_io.sv
tb_erx_io.sv

/* erx_io.sv */
// receive front end top, word and frame in, mesh packet out
// input is the DDR stage output, already in the rx_lclk domain
// no back-pressure on the receive path, waits only go to the pins
// rx_access latency varies with the slow phase, 1 to 4 cycles extra

`timescale 1ns/1ps

module erx_io
(
   input  logic                  rx_lclk,
   input  logic                  erx_io_nreset,
   input  erx_pkg::erx_word_t    rx_word,
   input  logic                  rx_frame,
   input  logic                  rx_wr_wait,
   input  logic                  rx_rd_wait,
   output logic                  rx_access,
   output logic                  rx_burst,
   output erx_pkg::erx_packet_t  rx_packet,
   output logic                  rxo_wr_wait,
   output logic                  rxo_rd_wait
);

   import erx_pkg::*;

   erx_frame_t   frame_w;     // decode to remap
   erx_packet_t  packet_w;    // remap to handoff
   logic         access_w;
   logic         burst_w;

   // ############################
   // decode
   // ############################
   erx_word_decode u_decode
   (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .rx_word       (rx_word),
      .rx_frame      (rx_frame),
      .frame_out     (frame_w)
   );

   // ############################
   // execute
   // ############################
   erx_packet_remap u_remap
   (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .frame_in      (frame_w),
      .packet        (packet_w),
      .access        (access_w),
      .burst         (burst_w)
   );

   // result, quarter rate side
   erx_slow_handoff u_handoff
   (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .access        (access_w),
      .burst         (burst_w),
      .packet        (packet_w),
      .rx_wr_wait    (rx_wr_wait),
      .rx_rd_wait    (rx_rd_wait),
      .rx_access     (rx_access),
      .rx_burst      (rx_burst),
      .rx_packet     (rx_packet),
      .rxo_wr_wait   (rxo_wr_wait),
      .rxo_rd_wait   (rxo_rd_wait)
   );

endmodule

/* erx_macros.svh */
// shared sizes for the receive front end
// ERX_INVERT_PINS is fixed per board build, 1 only for the inverted variant
// changing ERX_WORDS or ERX_BURST_SLOT alters the frame format on the link

`ifndef ERX_MACROS_SVH
`define ERX_MACROS_SVH

// ############################
// widths
// ############################
`define ERX_PW 104            // mesh packet bits
`define ERX_SW 112            // raw sample bits, 7 words of 16

// ############################
// frame format
// ############################
`define ERX_WORDS 7           // words in a full frame
`define ERX_BURST_SLOT 3      // follow-on restarts at the fourth word

// pushback polarity, 0 normal board
`define ERX_INVERT_PINS 0

`endif

/* erx_packet_remap.sv */
// execute stage of the receive front end
// byte order on the link is most significant byte first per field
// packet only changes on an access strobe, so a burst follow-on keeps
// the dstaddr and modes of the sample it shares words 0 to 2 with

`timescale 1ns/1ps

`include "erx_macros.svh"

module erx_packet_remap
(
   input  logic                 rx_lclk,
   input  logic                 erx_io_nreset,
   input  erx_pkg::erx_frame_t  frame_in,
   output erx_pkg::erx_packet_t packet,
   output logic                 access,
   output logic                 burst
);

   import erx_pkg::*;

   erx_sample_t         s;           // short name for the shuffle
   logic [`ERX_PW-1:0]  shuffled;    // packet bits in mesh order

   assign s = frame_in.sample;

   // ############################
   // byte shuffle
   // ############################
   assign shuffled = {
      s[87:80], s[95:88], s[103:96], s[111:104],    // srcaddr
      s[55:48], s[63:56], s[71:64],  s[79:72],      // data
      s[11:8],  s[23:16], s[31:24],  s[39:32],      // dstaddr upper
      s[47:44],                                     // dstaddr low nibble
      s[15:12],                                     // ctrlmode
      s[43:42],                                     // datamode
      s[41],                                        // write
      s[40]                                         // access
   };

   // payload hold, loaded only on a strobe
   always_ff @(posedge rx_lclk)
   begin
      if (frame_in.access)
         packet <= erx_packet_t'(shuffled);
   end

   // burst level sampled with the packet
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         access <= 1'b0;
         burst  <= 1'b0;
      end
      else
      begin
         access <= frame_in.access;   // one cycle behind decode
         if (frame_in.access)
            burst <= frame_in.burst;
      end
   end

endmodule

/* erx_pkg.sv */
// types for the receive front end
// sample is word 0 in the low bits, as it arrives on the link
// packet layout matches the mesh packet bit order, access in bit 0

`include "erx_macros.svh"

package erx_pkg;

   // one DDR cycle, two bytes
   typedef logic [15:0] erx_word_t;

   // full frame as written by the pointer
   typedef logic [`ERX_SW-1:0] erx_sample_t;

   typedef logic [31:0] erx_addr_t;   // dstaddr and srcaddr
   typedef logic [31:0] erx_data_t;
   typedef logic [3:0]  erx_mode_t;   // ctrlmode

   // mesh packet, top bit first
   typedef struct packed
   {
      erx_addr_t  srcaddr;
      erx_data_t  data;
      erx_addr_t  dstaddr;
      erx_mode_t  ctrlmode;
      logic [1:0] datamode;
      logic       write;
      logic       access;
   } erx_packet_t;

   // decode to remap handoff
   typedef struct packed
   {
      erx_sample_t sample;
      logic        access;    // one cycle per complete sample
      logic        burst;     // level, follow-on in progress
   } erx_frame_t;

endpackage

/* erx_slow_handoff.sv */
// result stage of the receive front end
// the slow side is a quarter-rate enable inside rx_lclk, not a clock
// packets must be at least 4 cycles apart, a shorter gap merges strobes
// wait outputs reset to the inverted idle level when pins are inverted

`timescale 1ns/1ps

`include "erx_macros.svh"

module erx_slow_handoff
(
   input  logic                  rx_lclk,
   input  logic                  erx_io_nreset,
   input  logic                  access,
   input  logic                  burst,
   input  erx_pkg::erx_packet_t  packet,
   input  logic                  rx_wr_wait,
   input  logic                  rx_rd_wait,
   output logic                  rx_access,
   output logic                  rx_burst,
   output erx_pkg::erx_packet_t  rx_packet,
   output logic                  rxo_wr_wait,
   output logic                  rxo_rd_wait
);

   import erx_pkg::*;

   localparam logic INVERT_PINS = 1'(`ERX_INVERT_PINS);

   logic [2:0] valid;         // stretch shift register
   logic       access_wide;
   logic [1:0] phase;         // divide-by-4 phase
   logic       slow_en;

   // ############################
   // strobe stretch
   // ############################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         valid <= 3'b000;
      else if (access)
         valid <= 3'b111;
      else
         valid <= {valid[1:0], 1'b0};
   end

   // strobe cycle plus 3, lines up with the packet hold
   assign access_wide = access | valid[2];   // high 4 cycles per packet

   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         phase <= 2'd0;
      else
         phase <= phase + 2'd1;   // free running
   end

   assign slow_en = (phase == 2'd3);   // one slow edge per 4 cycles

   // ############################
   // slow side registers
   // ############################
   always_ff @(posedge rx_lclk)
   begin
      if (slow_en && access_wide)
         rx_packet <= packet;
   end

   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         rx_access <= 1'b0;
         rx_burst  <= 1'b0;
      end
      else if (slow_en)
      begin
         rx_access <= access_wide;   // held a full slow period
         if (access_wide)
            rx_burst <= burst;
      end
   end

   // pushback to the link pins, one cycle
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         rxo_wr_wait <= INVERT_PINS;
         rxo_rd_wait <= INVERT_PINS;
      end
      else
      begin
         rxo_wr_wait <= rx_wr_wait ^ INVERT_PINS;
         rxo_rd_wait <= rx_rd_wait ^ INVERT_PINS;
      end
   end

endmodule

/* erx_word_decode.sv */
// decode stage of the receive front end
// rx_word and rx_frame are assumed already in the rx_lclk domain
// a follow-on frame only refills words 3 to 6, the rest of the sample
// is kept from the packet before it
// sample has no reset, only valid once access has fired

`timescale 1ns/1ps

`include "erx_macros.svh"

module erx_word_decode
(
   input  logic                 rx_lclk,
   input  logic                 erx_io_nreset,
   input  erx_pkg::erx_word_t   rx_word,
   input  logic                 rx_frame,
   output erx_pkg::erx_frame_t  frame_out
);

   import erx_pkg::*;

   localparam int WW = $bits(erx_word_t);   // bits per word

   erx_word_t              word_q;          // registered word
   logic                   frame_q;         // registered frame
   logic [`ERX_WORDS-1:0]  wr_ptr;          // one-hot write slot
   erx_sample_t            sample;
   logic                   access;
   logic                   burst_det;

   // ############################
   // input register
   // ############################
   always_ff @(posedge rx_lclk)
   begin
      word_q <= rx_word;   // payload, no reset
   end

   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         frame_q <= 1'b0;
      else
         frame_q <= rx_frame;
   end

   // ############################
   // write pointer
   // ############################
   // last slot looks at the early frame bit to catch a burst
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         wr_ptr <= `ERX_WORDS'(1);
      else if (wr_ptr[`ERX_WORDS-1] && rx_frame)
         wr_ptr <= `ERX_WORDS'(1) << `ERX_BURST_SLOT;   // anticipate follow-on
      else if (wr_ptr[`ERX_WORDS-1])
         wr_ptr <= `ERX_WORDS'(1);                      // wait for next frame
      else if (frame_q)
         wr_ptr <= {wr_ptr[`ERX_WORDS-2:0], 1'b0};       // mid frame
   end

   // word lands in the slot the pointer names
   // slot 0 gets idle words between frames, overwritten at frame start
   always_ff @(posedge rx_lclk)
   begin
      for (int i = 0; i < `ERX_WORDS; i++)
      begin
         if (wr_ptr[i])
            sample[i*WW +: WW] <= word_q;
      end
   end

   // ############################
   // access and burst
   // ############################
   // strobe rises with the last slot write, sample complete while high
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         access <= 1'b0;
      else
         access <= wr_ptr[`ERX_WORDS-1];
   end

   // frame still high at access means a follow-on is coming
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         burst_det <= 1'b0;
      else if (access && frame_q)
         burst_det <= 1'b1;
      else if (!frame_q)
         burst_det <= 1'b0;   // frame dropped, burst over
   end

   always_comb
   begin
      frame_out.sample = sample;
      frame_out.access = access;
      frame_out.burst  = burst_det;
   end

endmodule

/* run_sim.sh */
#!/bin/bash
# build and run the erx_io testbench with Verilator
# exit status is nonzero if the build, the run or the log check fails

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f compile.f --top-module tb_erx_io -o tb_erx_io
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_erx_io > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "=== FAIL ===" "$log"; then
   exit 1
fi
exit 0

/* tb_erx_io.sv */
// directed testbench for erx_io
// expected packets are built from the link byte layout, run in reverse
// expectations assume ERX_INVERT_PINS as set in the macro header
// bursts are sent from each of the four slow phases

`timescale 1ns/1ps

`include "erx_macros.svh"

module tb_erx_io;

   import erx_pkg::*;

   localparam logic INV        = 1'(`ERX_INVERT_PINS);
   localparam int   PACKETS    = 38;                    // sent over all tests
   localparam int   MAX_CYCLES = PACKETS * 40 + 400;    // watchdog budget

   logic         rx_lclk;
   logic         erx_io_nreset;
   erx_word_t    rx_word;
   logic         rx_frame;
   logic         rx_wr_wait;
   logic         rx_rd_wait;
   logic         rx_access;
   logic         rx_burst;
   erx_packet_t  rx_packet;
   logic         rxo_wr_wait;
   logic         rxo_rd_wait;

   int           seed;
   int           hi_cnt;        // cycles rx_access has been high
   logic         acc_prev;
   int           packet_errs;
   int           flag_errs;
   int           wait_errs;
   int           other_errs;

   erx_packet_t  exp_q[$];
   logic         exp_burst_q[$];
   erx_packet_t  got_q[$];
   logic         got_burst_q[$];

   erx_io dut
   (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .rx_word       (rx_word),
      .rx_frame      (rx_frame),
      .rx_wr_wait    (rx_wr_wait),
      .rx_rd_wait    (rx_rd_wait),
      .rx_access     (rx_access),
      .rx_burst      (rx_burst),
      .rx_packet     (rx_packet),
      .rxo_wr_wait   (rxo_wr_wait),
      .rxo_rd_wait   (rxo_rd_wait)
   );

   always #5 rx_lclk = ~rx_lclk;   // 10 ns period

   // ############################
   // monitor
   // ############################
   // one packet per slow period of rx_access, a burst keeps it high
   always @(negedge rx_lclk)
   begin
      if (rx_access)
      begin
         if (!acc_prev || hi_cnt == 4)
         begin
            got_q.push_back(rx_packet);
            got_burst_q.push_back(rx_burst);
            hi_cnt = 1;
         end
         else
            hi_cnt = hi_cnt + 1;
      end
      else
      begin
         if (acc_prev)
            check_flag(hi_cnt == 4, 1'b1, "rx_access held for one slow period");
         hi_cnt = 0;
      end
      acc_prev = rx_access;
   end

   // ############################
   // compare tasks
   // ############################
   function automatic string diff_fields(erx_packet_t a, erx_packet_t b);
      string s;
      s = "";
      if (a.srcaddr !== b.srcaddr)
         s = {s, " srcaddr"};
      if (a.data !== b.data)
         s = {s, " data"};
      if (a.dstaddr !== b.dstaddr)
         s = {s, " dstaddr"};
      if (a.ctrlmode !== b.ctrlmode)
         s = {s, " ctrlmode"};
      if ({a.datamode, a.write, a.access} !== {b.datamode, b.write, b.access})
         s = {s, " datamode/write/access"};
      return s;
   endfunction

   task automatic check_packet(erx_packet_t got, erx_packet_t exp, string what);
      if (got !== exp)
      begin
         packet_errs++;
         $display("Error at %0t: %s packet differs in%s, got %h expected %h",
                  $time, what, diff_fields(got, exp), got, exp);
      end
   endtask

   task automatic check_flag(logic got, logic exp, string what);
      if (got !== exp)
      begin
         flag_errs++;
         $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_wait(logic got, logic exp, string what);
      if (got !== exp)
      begin
         wait_errs++;
         $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   // ############################
   // drivers
   // ############################
   // inverse of the remap byte layout, msb of each field first on the link
   function automatic erx_sample_t build_sample(erx_packet_t p);
      erx_sample_t s;
      s = '0;
      s[15:12]  = p.ctrlmode;
      s[11:8]   = p.dstaddr[31:28];
      s[23:16]  = p.dstaddr[27:20];
      s[31:24]  = p.dstaddr[19:12];
      s[39:32]  = p.dstaddr[11:4];
      s[47:44]  = p.dstaddr[3:0];
      s[40]     = p.access;
      s[41]     = p.write;
      s[43:42]  = p.datamode;
      for (int b = 0; b < 4; b++)
      begin
         s[48 + 8*b +: 8] = p.data[31 - 8*b -: 8];      // data, words 3 to 4
         s[80 + 8*b +: 8] = p.srcaddr[31 - 8*b -: 8];   // srcaddr, words 5 to 6
      end
      return s;
   endfunction

   task automatic make_random_packet(output erx_packet_t p);
      logic [31:0] r;
      r = $random(seed);
      p.srcaddr = r;
      r = $random(seed);
      p.data = r;
      r = $random(seed);
      p.dstaddr = r;
      r = $random(seed);
      p.ctrlmode = r[3:0];
      p.datamode = r[5:4];
      p.write    = r[6];
      p.access   = r[7];
   endtask

   // words first to last of a sample, frame held high
   task automatic send_words(erx_sample_t s, int first, int last);
      for (int i = first; i <= last; i++)
      begin
         @(posedge rx_lclk);
         #1;
         rx_frame = 1'b1;
         rx_word  = s[i*16 +: 16];
      end
   endtask

   task automatic send_frame(erx_packet_t p);
      send_words(build_sample(p), 0, `ERX_WORDS-1);
   endtask

   task automatic idle_cycles(int n);
      repeat (n)
      begin
         @(posedge rx_lclk);
         #1;
         rx_frame = 1'b0;
         rx_word  = ~rx_word;   // junk on the bus between frames
      end
   endtask

   task automatic expect_packet(erx_packet_t p, logic burst);
      exp_q.push_back(p);
      exp_burst_q.push_back(burst);
   endtask

   task automatic collect_and_compare(string what);
      int          n;
      erx_packet_t g;
      erx_packet_t e;
      logic        gb;
      logic        eb;
      n = exp_q.size();
      while (got_q.size() < n)
         @(posedge rx_lclk);
      repeat (12) @(posedge rx_lclk);   // quiet window, stray pulses show here
      if (got_q.size() != n)
      begin
         other_errs++;
         $display("%s: expected %0d packets but the monitor saw %0d", what, n, got_q.size());
      end
      while (exp_q.size() > 0 && got_q.size() > 0)
      begin
         g  = got_q.pop_front();
         e  = exp_q.pop_front();
         gb = got_burst_q.pop_front();
         eb = exp_burst_q.pop_front();
         check_packet(g, e, what);
         check_flag(gb, eb, {what, " rx_burst"});
      end
      exp_q.delete();
      exp_burst_q.delete();
      got_q.delete();
      got_burst_q.delete();
   endtask

   task automatic apply_reset();
      erx_io_nreset = 1'b0;
      repeat (5) @(posedge rx_lclk);
      #1;
      erx_io_nreset = 1'b1;
   endtask

   // ############################
   // tests
   // ############################
   task automatic reset_values();
      check_flag(rx_access, 1'b0, "rx_access after reset");
      check_flag(rx_burst, 1'b0, "rx_burst after reset");
      check_wait(rxo_wr_wait, INV, "rxo_wr_wait after reset");
      check_wait(rxo_rd_wait, INV, "rxo_rd_wait after reset");
   endtask

   task automatic single_fixed_frame();
      erx_packet_t p;
      p.srcaddr  = 32'h1234_5678;
      p.data     = 32'hdead_beef;
      p.dstaddr  = 32'h8765_4321;
      p.ctrlmode = 4'h5;
      p.datamode = 2'b10;
      p.write    = 1'b1;
      p.access   = 1'b1;
      expect_packet(p, 1'b0);
      send_frame(p);
      idle_cycles(2);
      collect_and_compare("fixed frame");
   endtask

   task automatic random_frames();
      erx_packet_t p;
      logic [31:0] r;
      for (int k = 0; k < 20; k++)
      begin
         make_random_packet(p);
         expect_packet(p, 1'b0);
         send_frame(p);
         r = $random(seed);
         idle_cycles(int'(r % 32'd6) + 1);   // gap of 1 to 6
      end
      collect_and_compare("random frame");
   endtask

   // follow-on keeps words 0 to 2, new data and srcaddr only
   // start shifts by one cycle per round against the slow edge
   task automatic burst_sequence();
      erx_packet_t p;
      erx_packet_t nxt;
      for (int ph = 0; ph < 4; ph++)
      begin
         idle_cycles(ph + 1);
         make_random_packet(p);
         expect_packet(p, 1'b0);
         send_frame(p);
         for (int k = 0; k < 3; k++)
         begin
            make_random_packet(nxt);
            send_words(build_sample(nxt), `ERX_BURST_SLOT, `ERX_WORDS-1);
            p.data    = nxt.data;
            p.srcaddr = nxt.srcaddr;
            expect_packet(p, 1'b1);
         end
         idle_cycles(2);
         collect_and_compare("burst");
      end
   endtask

   // registered output holds the old level until the next edge
   task automatic toggle_waits(int n);
      logic [31:0] r;
      logic        wr_prev;
      logic        rd_prev;
      wr_prev = rx_wr_wait;
      rd_prev = rx_rd_wait;
      repeat (n)
      begin
         @(posedge rx_lclk);
         #1;
         check_wait(rxo_wr_wait, wr_prev ^ INV, "rxo_wr_wait");
         check_wait(rxo_rd_wait, rd_prev ^ INV, "rxo_rd_wait");
         r = $random(seed);
         rx_wr_wait = r[0];
         rx_rd_wait = r[1];
         @(negedge rx_lclk);
         check_wait(rxo_wr_wait, wr_prev ^ INV, "rxo_wr_wait before the edge");
         check_wait(rxo_rd_wait, rd_prev ^ INV, "rxo_rd_wait before the edge");
         wr_prev    = r[0];
         rd_prev    = r[1];
      end
   endtask

   task automatic wait_passthrough();
      erx_packet_t p;
      make_random_packet(p);
      expect_packet(p, 1'b0);
      fork
         toggle_waits(40);
         begin
            idle_cycles(3);
            send_frame(p);   // frame arrives while waits toggle
            idle_cycles(2);
         end
      join
      collect_and_compare("frame during wait toggling");
   endtask

   // ############################
   // main sequence and watchdog
   // ############################
   initial
   begin
      rx_lclk       = 1'b0;
      erx_io_nreset = 1'b0;
      rx_word       = '0;
      rx_frame      = 1'b0;
      rx_wr_wait    = 1'b0;
      rx_rd_wait    = 1'b0;
      seed          = 68;
      hi_cnt        = 0;
      acc_prev      = 1'b0;
      packet_errs   = 0;
      flag_errs     = 0;
      wait_errs     = 0;
      other_errs    = 0;
      apply_reset();
      reset_values();
      single_fixed_frame();
      random_frames();
      burst_sequence();
      wait_passthrough();
      $display("Errors: packet %0d, flag %0d, wait %0d, other %0d",
               packet_errs, flag_errs, wait_errs, other_errs);
      if (packet_errs + flag_errs + wait_errs + other_errs == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      #(MAX_CYCLES * 10);
      $display("Watchdog: run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
   end

endmodule
